// File: common/matmul_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Row-wide memory port, one cycle read latency
interface mem_port_if #(
  parameter int RWIDTH = $bits(matmul_pkg::row_u),
  parameter int AWIDTH = matmul_pkg::AWIDTH
) ();
  import matmul_pkg::*;

  logic [AWIDTH-1:0] addr;
  row_u              wdata;
  logic              we;
  row_u              rdata;

  modport ctrl (output addr, output wdata, output we, input rdata);
  modport mem (input addr, input wdata, input we, output rdata);

  // Row type comes from the package, width must agree with the instance
  initial begin
    assert (RWIDTH == $bits(row_u))
      else $error("mem_port_if: row width %0d does not match row_u", RWIDTH);
  end

endinterface

// Operand feed into the systolic array
interface pe_feed_if ();
  import matmul_pkg::*;

  row_u a_col;
  row_u b_row;
  logic valid;
  logic clear;

  modport src (output a_col, output b_row, output valid, output clear);
  modport snk (input a_col, input b_row, input valid, input clear);

endinterface

`default_nettype wire

// File: common/matmul_pkg.sv
`default_nettype none

package matmul_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////
  localparam int DWIDTH   = 8;
  localparam int MAT_SIZE = 4;
  localparam int AWIDTH   = 6;

  localparam int REG_DWIDTH = 32;
  localparam int REG_AWIDTH = 8;

  //////////////////////////////
  // Register map
  //////////////////////////////
  localparam logic [REG_AWIDTH-1:0] REG_CTRL_ADDR   = 8'h00;
  localparam logic [REG_AWIDTH-1:0] REG_A_BASE_ADDR = 8'h0E;
  localparam logic [REG_AWIDTH-1:0] REG_B_BASE_ADDR = 8'h12;
  localparam logic [REG_AWIDTH-1:0] REG_C_BASE_ADDR = 8'h16;

  // Control word bits
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_DONE_BIT  = 31;

  // External port bank codes, code 3 selects nothing
  localparam logic [1:0] BANK_A = 2'd0;
  localparam logic [1:0] BANK_B = 2'd1;
  localparam logic [1:0] BANK_C = 2'd2;

  // One memory row, seen flat or as N elements
  typedef union packed {
    logic [MAT_SIZE*DWIDTH-1:0]      raw;
    logic [MAT_SIZE-1:0][DWIDTH-1:0] elem;
  } row_u;

endpackage

`default_nettype wire

// File: hdl/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs #(
  parameter int AWIDTH = matmul_pkg::AWIDTH
) (
  input  logic                              clk,
  input  logic                              PRESETn,
  input  logic [matmul_pkg::REG_AWIDTH-1:0] PADDR,
  input  logic                              PWRITE,
  input  logic                              PSEL,
  input  logic                              PENABLE,
  input  logic [matmul_pkg::REG_DWIDTH-1:0] PWDATA,
  output logic [matmul_pkg::REG_DWIDTH-1:0] PRDATA,
  output logic                              PREADY,
  input  logic                              done,
  input  logic                              busy,
  output logic                              start,
  output logic [AWIDTH-1:0]                 a_base,
  output logic [AWIDTH-1:0]                 b_base,
  output logic [AWIDTH-1:0]                 c_base
);
  import matmul_pkg::*;

  typedef enum logic [1:0] {APB_IDLE, APB_W_ENABLE, APB_R_ENABLE} apb_state_e;

  apb_state_e            state;
  logic                  done_flag;
  logic [REG_DWIDTH-1:0] scratch;
  logic [REG_DWIDTH-1:0] ctrl_rd;

  // Status view of the control word
  always_comb begin
    ctrl_rd = '0;
    ctrl_rd[CTRL_DONE_BIT] = done_flag;
    ctrl_rd[CTRL_START_BIT] = busy;
  end

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state     <= APB_IDLE;
      PRDATA    <= '0;
      PREADY    <= 1'b0;
      start     <= 1'b0;
      done_flag <= 1'b0;
      a_base    <= '0;
      b_base    <= '0;
      c_base    <= '0;
      scratch   <= '0;
    end else begin
      start  <= 1'b0;
      PREADY <= 1'b0;
      PRDATA <= '0;
      case (state)
        // Only a setup phase opens a transfer
        APB_IDLE: begin
          if (PSEL && !PENABLE) begin
            state <= PWRITE ? APB_W_ENABLE : APB_R_ENABLE;
          end
        end
        APB_W_ENABLE: begin
          if (PSEL && PENABLE && PWRITE) begin
            PREADY <= 1'b1;
            case (PADDR)
              REG_CTRL_ADDR: begin
                start <= PWDATA[CTRL_START_BIT];
                if (PWDATA[CTRL_DONE_BIT]) begin
                  done_flag <= 1'b0;
                end
              end
              REG_A_BASE_ADDR: a_base <= PWDATA[AWIDTH-1:0];
              REG_B_BASE_ADDR: b_base <= PWDATA[AWIDTH-1:0];
              REG_C_BASE_ADDR: c_base <= PWDATA[AWIDTH-1:0];
              default:         scratch <= PWDATA;
            endcase
          end
          state <= APB_IDLE;
        end
        APB_R_ENABLE: begin
          if (PSEL && PENABLE && !PWRITE) begin
            PREADY <= 1'b1;
            case (PADDR)
              REG_CTRL_ADDR:   PRDATA <= ctrl_rd;
              REG_A_BASE_ADDR: PRDATA <= REG_DWIDTH'(a_base);
              REG_B_BASE_ADDR: PRDATA <= REG_DWIDTH'(b_base);
              REG_C_BASE_ADDR: PRDATA <= REG_DWIDTH'(c_base);
              default:         PRDATA <= scratch;
            endcase
          end
          state <= APB_IDLE;
        end
        default: state <= APB_IDLE;
      endcase
      // Completion wins over a clear in the same cycle
      if (done) begin
        done_flag <= 1'b1;
      end
    end
  end

  a_ready_in_transfer: assert property (@(posedge clk) disable iff (!PRESETn)
    PREADY |-> PSEL);

endmodule

`default_nettype wire

// File: hdl/matmul_top.sv
`timescale 1ns/1ps
`default_nettype none

module matmul_top #(
  parameter int MAT_SIZE = matmul_pkg::MAT_SIZE,
  parameter int AWIDTH   = matmul_pkg::AWIDTH
) (
  input  logic                                 clk,
  input  logic                                 PRESETn,
  input  logic [matmul_pkg::REG_AWIDTH-1:0]    PADDR,
  input  logic                                 PWRITE,
  input  logic                                 PSEL,
  input  logic                                 PENABLE,
  input  logic [matmul_pkg::REG_DWIDTH-1:0]    PWDATA,
  output logic [matmul_pkg::REG_DWIDTH-1:0]    PRDATA,
  output logic                                 PREADY,
  input  logic [1:0]                           bram_select,
  input  logic [AWIDTH-1:0]                    bram_addr_ext,
  input  logic [MAT_SIZE*matmul_pkg::DWIDTH-1:0] bram_wdata_ext,
  input  logic                                 bram_we_ext,
  output logic [MAT_SIZE*matmul_pkg::DWIDTH-1:0] bram_rdata_ext
);
  import matmul_pkg::*;

  localparam int RWIDTH = MAT_SIZE * DWIDTH;

  logic                     start;
  logic                     done;
  logic                     busy;
  logic [AWIDTH-1:0]        a_base;
  logic [AWIDTH-1:0]        b_base;
  logic [AWIDTH-1:0]        c_base;
  row_u [MAT_SIZE-1:0]      c_matrix;
  logic                     a_ext_we;
  logic                     b_ext_we;
  logic                     c_ext_we;
  logic [RWIDTH-1:0]        a_ext_rdata;
  logic [RWIDTH-1:0]        b_ext_rdata;
  logic [RWIDTH-1:0]        c_ext_rdata;
  logic [1:0]               sel_q;

  mem_port_if #(.RWIDTH(RWIDTH), .AWIDTH(AWIDTH)) a_bus ();
  mem_port_if #(.RWIDTH(RWIDTH), .AWIDTH(AWIDTH)) b_bus ();
  mem_port_if #(.RWIDTH(RWIDTH), .AWIDTH(AWIDTH)) c_bus ();
  pe_feed_if feed ();

  //////////////////////////////
  // External port bank decode
  //////////////////////////////
  assign a_ext_we = bram_we_ext && (bram_select == BANK_A);
  assign b_ext_we = bram_we_ext && (bram_select == BANK_B);
  assign c_ext_we = bram_we_ext && (bram_select == BANK_C);

  // Select follows the address through the read latency
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      sel_q <= '1;
    end else begin
      sel_q <= bram_select;
    end
  end

  always_comb begin
    case (sel_q)
      BANK_A:  bram_rdata_ext = a_ext_rdata;
      BANK_B:  bram_rdata_ext = b_ext_rdata;
      BANK_C:  bram_rdata_ext = c_ext_rdata;
      default: bram_rdata_ext = '0;
    endcase
  end

  apb_regs #(.AWIDTH(AWIDTH)) u_apb_regs (
    .clk(clk), .PRESETn(PRESETn), .PADDR(PADDR), .PWRITE(PWRITE), .PSEL(PSEL),
    .PENABLE(PENABLE), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
    .done(done), .busy(busy), .start(start),
    .a_base(a_base), .b_base(b_base), .c_base(c_base)
  );

  //////////////////////////////
  // Matrix memories
  //////////////////////////////
  row_ram #(.MAT_SIZE(MAT_SIZE), .AWIDTH(AWIDTH)) a_ram (
    .clk(clk), .int_port(a_bus.mem), .ext_addr(bram_addr_ext),
    .ext_wdata(bram_wdata_ext), .ext_we(a_ext_we), .ext_rdata(a_ext_rdata)
  );

  row_ram #(.MAT_SIZE(MAT_SIZE), .AWIDTH(AWIDTH)) b_ram (
    .clk(clk), .int_port(b_bus.mem), .ext_addr(bram_addr_ext),
    .ext_wdata(bram_wdata_ext), .ext_we(b_ext_we), .ext_rdata(b_ext_rdata)
  );

  row_ram #(.MAT_SIZE(MAT_SIZE), .AWIDTH(AWIDTH)) c_ram (
    .clk(clk), .int_port(c_bus.mem), .ext_addr(bram_addr_ext),
    .ext_wdata(bram_wdata_ext), .ext_we(c_ext_we), .ext_rdata(c_ext_rdata)
  );

  //////////////////////////////
  // Compute core
  //////////////////////////////
  systolic_sequencer #(.MAT_SIZE(MAT_SIZE), .AWIDTH(AWIDTH)) u_sequencer (
    .clk(clk), .PRESETn(PRESETn), .start(start),
    .a_base(a_base), .b_base(b_base), .c_base(c_base), .c_matrix(c_matrix),
    .busy(busy), .done(done),
    .a_port(a_bus.ctrl), .b_port(b_bus.ctrl), .c_port(c_bus.ctrl), .feed(feed.src)
  );

  systolic_array #(.MAT_SIZE(MAT_SIZE)) u_array (
    .clk(clk), .PRESETn(PRESETn), .feed(feed.snk), .c_matrix(c_matrix)
  );

endmodule

`default_nettype wire

// File: hdl/row_ram.sv
`timescale 1ns/1ps
`default_nettype none

module row_ram #(
  parameter int MAT_SIZE = matmul_pkg::MAT_SIZE,
  parameter int AWIDTH   = matmul_pkg::AWIDTH
) (
  input  logic                                   clk,
  mem_port_if.mem                                int_port,
  input  logic [AWIDTH-1:0]                      ext_addr,
  input  logic [MAT_SIZE*matmul_pkg::DWIDTH-1:0] ext_wdata,
  input  logic                                   ext_we,
  output logic [MAT_SIZE*matmul_pkg::DWIDTH-1:0] ext_rdata
);
  import matmul_pkg::*;

  row_u mem [2**AWIDTH];

  // Internal write comes last so it wins on a shared row
  always_ff @(posedge clk) begin
    if (ext_we) begin
      mem[ext_addr].raw <= ext_wdata;
    end
    if (int_port.we) begin
      mem[int_port.addr] <= int_port.wdata;
    end
  end

  // Registered reads, old data on a same-cycle write
  always_ff @(posedge clk) begin
    int_port.rdata <= mem[int_port.addr];
    ext_rdata      <= mem[ext_addr].raw;
  end

endmodule

`default_nettype wire

// File: matmul_top.f
common/matmul_pkg.sv
common/matmul_ifs.sv
hdl/apb_regs.sv
hdl/row_ram.sv
systolic/systolic_sequencer.sv
systolic/systolic_array.sv
hdl/matmul_top.sv
tb/tb_matmul_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the matmul testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_matmul_top -Mdir obj_dir -f matmul_top.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/Vtb_matmul_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1

// File: systolic/systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_array #(
  parameter int MAT_SIZE = matmul_pkg::MAT_SIZE
) (
  input  logic                            clk,
  input  logic                            PRESETn,
  pe_feed_if.snk                          feed,
  output matmul_pkg::row_u [MAT_SIZE-1:0] c_matrix
);
  import matmul_pkg::*;

  // Cell inputs, a and its valid move right, b moves down
  logic [DWIDTH-1:0] a_in  [MAT_SIZE][MAT_SIZE];
  logic              av_in [MAT_SIZE][MAT_SIZE];
  logic [DWIDTH-1:0] b_in  [MAT_SIZE][MAT_SIZE];
  logic [DWIDTH-1:0] acc   [MAT_SIZE][MAT_SIZE];

  //////////////////////////////
  // Input skew
  //////////////////////////////
  for (genvar g = 0; g < MAT_SIZE; g++) begin : g_skew
    if (g == 0) begin : g_direct
      assign a_in[0][0]  = feed.a_col.elem[0];
      assign av_in[0][0] = feed.valid;
      assign b_in[0][0]  = feed.b_row.elem[0];
    end else begin : g_delay
      logic [DWIDTH-1:0] a_sr [g];
      logic [DWIDTH-1:0] b_sr [g];
      logic              v_sr [g];

      always_ff @(posedge clk) begin
        if (!PRESETn) begin
          for (int s = 0; s < g; s++) begin
            v_sr[s] <= 1'b0;
          end
        end else begin
          v_sr[0] <= feed.valid;
          for (int s = 1; s < g; s++) begin
            v_sr[s] <= v_sr[s-1];
          end
        end
      end

      always_ff @(posedge clk) begin
        a_sr[0] <= feed.a_col.elem[g];
        b_sr[0] <= feed.b_row.elem[g];
        for (int s = 1; s < g; s++) begin
          a_sr[s] <= a_sr[s-1];
          b_sr[s] <= b_sr[s-1];
        end
      end

      assign a_in[g][0]  = a_sr[g-1];
      assign av_in[g][0] = v_sr[g-1];
      assign b_in[0][g]  = b_sr[g-1];
    end
  end

  //////////////////////////////
  // MAC grid
  //////////////////////////////
  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < MAT_SIZE; j++) begin : g_col
      // Product and sum wrap at DWIDTH bits
      always_ff @(posedge clk) begin
        if (!PRESETn || feed.clear) begin
          acc[i][j] <= '0;
        end else if (av_in[i][j]) begin
          acc[i][j] <= acc[i][j] + a_in[i][j] * b_in[i][j];
        end
      end

      if (j < MAT_SIZE - 1) begin : g_pass_a
        always_ff @(posedge clk) begin
          if (!PRESETn) begin
            av_in[i][j+1] <= 1'b0;
          end else begin
            av_in[i][j+1] <= av_in[i][j];
          end
        end
        always_ff @(posedge clk) begin
          a_in[i][j+1] <= a_in[i][j];
        end
      end

      if (i < MAT_SIZE - 1) begin : g_pass_b
        always_ff @(posedge clk) begin
          b_in[i+1][j] <= b_in[i][j];
        end
      end

      assign c_matrix[i].elem[j] = acc[i][j];
    end
  end

  a_clear_not_with_valid: assert property (@(posedge clk) disable iff (!PRESETn)
    !(feed.clear && feed.valid));

endmodule

`default_nettype wire

// File: systolic/systolic_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_sequencer #(
  parameter int MAT_SIZE = matmul_pkg::MAT_SIZE,
  parameter int AWIDTH   = matmul_pkg::AWIDTH
) (
  input  logic                               clk,
  input  logic                               PRESETn,
  input  logic                               start,
  input  logic [AWIDTH-1:0]                  a_base,
  input  logic [AWIDTH-1:0]                  b_base,
  input  logic [AWIDTH-1:0]                  c_base,
  input  matmul_pkg::row_u [MAT_SIZE-1:0]    c_matrix,
  output logic                               busy,
  output logic                               done,
  mem_port_if.ctrl                           a_port,
  mem_port_if.ctrl                           b_port,
  mem_port_if.ctrl                           c_port,
  pe_feed_if.src                             feed
);
  import matmul_pkg::*;

  localparam int STEP_W = $clog2(2 * MAT_SIZE);
  localparam int ROW_W  = (MAT_SIZE > 1) ? $clog2(MAT_SIZE) : 1;
  localparam logic [STEP_W-1:0] LOAD_LAST  = STEP_W'(MAT_SIZE - 1);
  localparam logic [STEP_W-1:0] DRAIN_LAST = STEP_W'(2 * MAT_SIZE - 2);
  localparam logic [ROW_W-1:0]  ROW_LAST   = ROW_W'(MAT_SIZE - 1);

  typedef enum logic [2:0] {S_IDLE, S_LOAD, S_DRAIN, S_WRITE, S_FINISH} seq_state_e;

  seq_state_e        state;
  logic [STEP_W-1:0] step;
  logic [ROW_W-1:0]  row;
  logic              clear_q;
  logic              valid_q;

  //////////////////////////////
  // Control FSM
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state   <= S_IDLE;
      step    <= '0;
      row     <= '0;
      clear_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      clear_q <= 1'b0;
      // Read data lands one cycle after each load step
      valid_q <= (state == S_LOAD);
      case (state)
        S_IDLE: begin
          if (start) begin
            state   <= S_LOAD;
            step    <= '0;
            clear_q <= 1'b1;
          end
        end
        S_LOAD: begin
          if (step == LOAD_LAST) begin
            state <= S_DRAIN;
            step  <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        // 2N-1 cycles for the last word to cross the grid
        S_DRAIN: begin
          if (step == DRAIN_LAST) begin
            state <= S_WRITE;
            row   <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        S_WRITE: begin
          if (row == ROW_LAST) begin
            state <= S_FINISH;
          end else begin
            row <= row + 1'b1;
          end
        end
        S_FINISH: state <= S_IDLE;
        default:  state <= S_IDLE;
      endcase
    end
  end

  assign busy = (state != S_IDLE);
  assign done = (state == S_FINISH);

  // Operand reads, A and B are never written from here
  assign a_port.addr  = a_base + AWIDTH'(step);
  assign a_port.wdata = '0;
  assign a_port.we    = 1'b0;
  assign b_port.addr  = b_base + AWIDTH'(step);
  assign b_port.wdata = '0;
  assign b_port.we    = 1'b0;

  // Result write-back, one row per cycle
  assign c_port.addr  = c_base + AWIDTH'(row);
  assign c_port.wdata = c_matrix[row];
  assign c_port.we    = (state == S_WRITE);

  assign feed.a_col = a_port.rdata;
  assign feed.b_row = b_port.rdata;
  assign feed.valid = valid_q;
  assign feed.clear = clear_q;

  a_operand_read_only: assert property (@(posedge clk) disable iff (!PRESETn)
    !a_port.we && !b_port.we);

endmodule

`default_nettype wire

// File: tb/tb_matmul_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_matmul_top;
  import matmul_pkg::*;

  localparam int N             = MAT_SIZE;
  localparam int RWIDTH        = MAT_SIZE * DWIDTH;
  localparam int READY_TIMEOUT = 20;
  localparam int DONE_POLLS    = 40;

  logic                  clk;
  logic                  PRESETn;
  logic [REG_AWIDTH-1:0] PADDR;
  logic                  PWRITE;
  logic                  PSEL;
  logic                  PENABLE;
  logic [REG_DWIDTH-1:0] PWDATA;
  logic [REG_DWIDTH-1:0] PRDATA;
  logic                  PREADY;
  logic [1:0]            bram_select;
  logic [AWIDTH-1:0]     bram_addr_ext;
  logic [RWIDTH-1:0]     bram_wdata_ext;
  logic                  bram_we_ext;
  logic [RWIDTH-1:0]     bram_rdata_ext;

  int                    errors;
  int                    timeouts;
  int                    seed;
  logic                  rd_chk;
  logic [REG_DWIDTH-1:0] rd_exp;
  logic [REG_DWIDTH-1:0] rd_val;
  logic                  mem_chk;
  logic [RWIDTH-1:0]     mem_exp;
  logic [DWIDTH-1:0]     a_mat [N][N];
  logic [DWIDTH-1:0]     b_mat [N][N];

  matmul_top #(.MAT_SIZE(MAT_SIZE), .AWIDTH(AWIDTH)) uut (
    .clk(clk), .PRESETn(PRESETn), .PADDR(PADDR), .PWRITE(PWRITE), .PSEL(PSEL),
    .PENABLE(PENABLE), .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY),
    .bram_select(bram_select), .bram_addr_ext(bram_addr_ext),
    .bram_wdata_ext(bram_wdata_ext), .bram_we_ext(bram_we_ext),
    .bram_rdata_ext(bram_rdata_ext)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Checkers
  //////////////////////////////
  a_ready_one_cycle: assert property (@(posedge clk) disable iff (!PRESETn)
    PREADY |-> !$past(PREADY))
    else begin
      errors++;
      $display("[FAIL] %0t: PREADY stayed high for a second cycle", $time);
    end

  a_rdata_idle_zero: assert property (@(posedge clk) disable iff (!PRESETn)
    !PREADY |-> (PRDATA == '0))
    else begin
      errors++;
      $display("[FAIL] %0t: PRDATA 0x%08h while PREADY low", $time, $sampled(PRDATA));
    end

  a_reset_outputs: assert property (@(posedge clk)
    $rose(PRESETn) |-> (!PREADY && PRDATA == '0))
    else begin
      errors++;
      $display("[FAIL] %0t: APB outputs not idle after reset", $time);
    end

  a_read_value: assert property (@(posedge clk) disable iff (!PRESETn)
    (PREADY && rd_chk) |-> (PRDATA == rd_exp))
    else begin
      errors++;
      $display("[FAIL] %0t: register 0x%02h read 0x%08h, expected 0x%08h", $time,
               $sampled(PADDR), $sampled(PRDATA), $sampled(rd_exp));
    end

  a_row_value: assert property (@(posedge clk) disable iff (!PRESETn)
    mem_chk |-> (bram_rdata_ext == mem_exp))
    else begin
      errors++;
      $display("[FAIL] %0t: bank %0d row 0x%02h read 0x%08h, expected 0x%08h", $time,
               $sampled(bram_select), $sampled(bram_addr_ext),
               $sampled(bram_rdata_ext), $sampled(mem_exp));
    end

  //////////////////////////////
  // APB and memory tasks
  //////////////////////////////
  task automatic apb_transfer(input logic write, input logic [REG_AWIDTH-1:0] addr,
                              input logic [REG_DWIDTH-1:0] wdata,
                              output logic [REG_DWIDTH-1:0] rdata);
    int cycles;
    cycles = 0;
    rdata = '0;
    @(negedge clk);
    PADDR = addr;
    PWRITE = write;
    PWDATA = wdata;
    PSEL = 1'b1;
    PENABLE = 1'b0;
    @(negedge clk);
    PENABLE = 1'b1;
    @(negedge clk);
    while (!PREADY && cycles < READY_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (PREADY) begin
      rdata = PRDATA;
    end else begin
      timeouts++;
      $display("Timeout: no PREADY for the transfer at address 0x%02h", addr);
    end
    // Hold the bus through the ready edge
    @(negedge clk);
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
  endtask

  task automatic reg_write(input logic [REG_AWIDTH-1:0] addr,
                           input logic [REG_DWIDTH-1:0] data);
    apb_transfer(1'b1, addr, data, rd_val);
  endtask

  task automatic reg_check(input logic [REG_AWIDTH-1:0] addr,
                           input logic [REG_DWIDTH-1:0] expected);
    rd_exp = expected;
    rd_chk = 1'b1;
    apb_transfer(1'b0, addr, '0, rd_val);
    rd_chk = 1'b0;
  endtask

  task automatic mem_write(input logic [1:0] bank, input logic [AWIDTH-1:0] addr,
                           input logic [RWIDTH-1:0] data);
    @(negedge clk);
    bram_select = bank;
    bram_addr_ext = addr;
    bram_wdata_ext = data;
    bram_we_ext = 1'b1;
    @(negedge clk);
    bram_we_ext = 1'b0;
  endtask

  // Row data shows up one cycle after the address
  task automatic mem_check(input logic [1:0] bank, input logic [AWIDTH-1:0] addr,
                           input logic [RWIDTH-1:0] expected);
    @(negedge clk);
    bram_select = bank;
    bram_addr_ext = addr;
    bram_we_ext = 1'b0;
    @(negedge clk);
    mem_exp = expected;
    mem_chk = 1'b1;
    @(negedge clk);
    mem_chk = 1'b0;
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Word k holds column k of A and row k of B
  task automatic load_matrices(input logic [AWIDTH-1:0] a_base,
                               input logic [AWIDTH-1:0] b_base);
    logic [RWIDTH-1:0] a_word;
    logic [RWIDTH-1:0] b_word;
    for (int k = 0; k < N; k++) begin
      for (int e = 0; e < N; e++) begin
        a_mat[e][k] = DWIDTH'($random(seed));
        b_mat[k][e] = DWIDTH'($random(seed));
        a_word[e*DWIDTH +: DWIDTH] = a_mat[e][k];
        b_word[e*DWIDTH +: DWIDTH] = b_mat[k][e];
      end
      mem_write(BANK_A, AWIDTH'(a_base + k), a_word);
      mem_write(BANK_B, AWIDTH'(b_base + k), b_word);
    end
  endtask

  // Column k of A as one memory word
  function automatic logic [RWIDTH-1:0] a_column_word(input int k);
    logic [RWIDTH-1:0] word;
    for (int e = 0; e < N; e++) begin
      word[e*DWIDTH +: DWIDTH] = a_mat[e][k];
    end
    return word;
  endfunction

  // Sum of products wraps at the element width
  function automatic logic [RWIDTH-1:0] product_row(input int i);
    logic [RWIDTH-1:0] row;
    logic [DWIDTH-1:0] sum;
    row = '0;
    for (int j = 0; j < N; j++) begin
      sum = '0;
      for (int k = 0; k < N; k++) begin
        sum = sum + a_mat[i][k] * b_mat[k][j];
      end
      row[j*DWIDTH +: DWIDTH] = sum;
    end
    return row;
  endfunction

  task automatic wait_done();
    logic [REG_DWIDTH-1:0] ctrl;
    int polls;
    ctrl = '0;
    polls = 0;
    while (!ctrl[CTRL_DONE_BIT] && polls < DONE_POLLS) begin
      apb_transfer(1'b0, REG_CTRL_ADDR, '0, ctrl);
      polls++;
    end
    if (!ctrl[CTRL_DONE_BIT]) begin
      timeouts++;
      $display("Timeout: the done flag never came up after a start");
    end
  endtask

  task automatic check_result(input logic [AWIDTH-1:0] c_base);
    for (int i = 0; i < N; i++) begin
      mem_check(BANK_C, AWIDTH'(c_base + i), product_row(i));
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    seed = 55857;
    errors = 0;
    timeouts = 0;
    rd_chk = 1'b0;
    rd_exp = '0;
    rd_val = '0;
    mem_chk = 1'b0;
    mem_exp = '0;
    PRESETn = 1'b0;
    PADDR = '0;
    PWRITE = 1'b0;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWDATA = '0;
    bram_select = BANK_A;
    bram_addr_ext = '0;
    bram_wdata_ext = '0;
    bram_we_ext = 1'b0;
    repeat (10) @(negedge clk);
    PRESETn = 1'b1;

    // Reset values
    reg_check(REG_A_BASE_ADDR, 32'h0);
    reg_check(REG_B_BASE_ADDR, 32'h0);
    reg_check(REG_C_BASE_ADDR, 32'h0);
    reg_check(8'h40, 32'h0);
    reg_check(REG_CTRL_ADDR, 32'h0);

    // Base registers and scratch
    reg_write(REG_A_BASE_ADDR, 32'h05);
    reg_write(REG_B_BASE_ADDR, 32'h0A);
    reg_write(REG_C_BASE_ADDR, 32'h20);
    reg_check(REG_A_BASE_ADDR, 32'h05);
    reg_check(REG_B_BASE_ADDR, 32'h0A);
    reg_check(REG_C_BASE_ADDR, 32'h20);
    reg_write(8'h44, 32'hCAFE_0123);
    reg_check(8'h7C, 32'hCAFE_0123);

    // External port with one row per bank
    mem_write(BANK_A, 6'h3F, 32'h1122_3344);
    mem_write(BANK_B, 6'h3F, 32'h5566_7788);
    mem_write(BANK_C, 6'h3F, 32'h99AA_BBCC);
    mem_check(BANK_A, 6'h3F, 32'h1122_3344);
    mem_check(BANK_B, 6'h3F, 32'h5566_7788);
    mem_check(BANK_C, 6'h3F, 32'h99AA_BBCC);
    mem_write(2'd3, 6'h3E, 32'hDEAD_BEEF);
    mem_check(2'd3, 6'h3E, 32'h0);

    // First product
    load_matrices(6'h05, 6'h0A);
    reg_write(REG_CTRL_ADDR, 32'h1);
    wait_done();
    check_result(6'h20);

    // A start while busy is dropped
    reg_write(REG_CTRL_ADDR, 32'h8000_0000);
    reg_write(REG_CTRL_ADDR, 32'h1);
    reg_check(REG_CTRL_ADDR, 32'h1);
    // Loads are over, only a restart would see this column
    mem_write(BANK_A, 6'h05, ~a_column_word(0));
    reg_write(REG_CTRL_ADDR, 32'h1);
    wait_done();
    reg_check(REG_CTRL_ADDR, 32'h8000_0000);
    check_result(6'h20);

    // Clear done and run a fresh product
    reg_write(REG_CTRL_ADDR, 32'h8000_0000);
    reg_check(REG_CTRL_ADDR, 32'h0);
    load_matrices(6'h05, 6'h0A);
    reg_write(REG_CTRL_ADDR, 32'h1);
    wait_done();
    check_result(6'h20);

    repeat (2) @(negedge clk);
    $display("Run complete: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
